//--- sources.f
design/serial_bus_pkg.sv
design/bin_to_bcd.sv
design/bus_arbiter.sv
design/bus_master_port.sv
design/bus_slave_port.sv
design/display_node.sv
design/serial_bus_top.sv
verification/serial_bus_assertions.sv
verification/tb_serial_bus.sv

//--- Makefile
# Verilator build and run for the serial bus testbench

VERILATOR ?= verilator
TOP       := tb_serial_bus
FILELIST  := sources.f
VFLAGS    := --binary --timing --assert -j 0
LINTFLAGS := --lint-only --timing
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := All checks passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q -x -F "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verification/tb_serial_bus.sv
// SETTLE_LEN here must match the DUT; the forward and contention tests depend on it
`default_nettype none

module tb_serial_bus;

    localparam int SETTLE_LEN = 4;
    localparam int FRAME_CYC  = serial_bus_pkg::FRAME_BITS + 2;  // uncontended host latency
    localparam int WAIT_LIMIT = (1 << SETTLE_LEN) + 3 * FRAME_CYC + 10;
    localparam int NUM_RAND   = 8;
    localparam int NUM_SENDS  = NUM_RAND + 12;
    localparam int WATCHDOG   = (NUM_SENDS * WAIT_LIMIT + 50) * 100;

    logic                         clk;
    logic                         rstn;
    logic                         host_start;
    serial_bus_pkg::bus_frame_t   host_frame;
    logic                         host_busy;
    logic                         host_done;
    logic                         bus_serial;
    logic                         bus_util;
    serial_bus_pkg::bcd_display_t display_a;
    serial_bus_pkg::bcd_display_t display_b;

    int cyc = 0;
    int done_cnt = 0;
    int test_errs = 0;
    int tests_run = 0;
    int tests_failed = 0;
    serial_bus_pkg::bcd_display_t b_log[$];  // each new value of display_b
    serial_bus_pkg::bcd_display_t prev_b = '0;
    serial_bus_pkg::bus_frame_t   rx_frames[$];  // frames seen on bus_serial
    serial_bus_pkg::bus_frame_t   rx_shift = '0;
    int                           rx_bits = 0;

    serial_bus_top #(.SETTLE_LEN(SETTLE_LEN)) uut (
        .clk        (clk),
        .rstn       (rstn),
        .host_start (host_start),
        .host_frame (host_frame),
        .host_busy  (host_busy),
        .host_done  (host_done),
        .display_a  (display_a),
        .display_b  (display_b),
        .bus_serial (bus_serial),
        .bus_util   (bus_util)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    always @(negedge clk)
    begin
        if (host_done)
            done_cnt++;
        if (display_b != prev_b)
        begin
            b_log.push_back(display_b);
            prev_b = display_b;
        end
        if (bus_util)
        begin
            rx_shift = {rx_shift[serial_bus_pkg::FRAME_BITS-2:0], bus_serial};  // msb first
            rx_bits++;
            if (rx_bits == serial_bus_pkg::FRAME_BITS)
            begin
                rx_frames.push_back(rx_shift);
                rx_bits = 0;
            end
        end
        else
            rx_bits = 0;
    end

    initial
    begin
        #(WATCHDOG);
        $display("watchdog expired before the tests finished");
        $display("Checks failed");
        $finish;
    end

    // decimal digits by division, independent of the shift-and-add circuit
    function automatic serial_bus_pkg::bcd_display_t expected_digits(input int v);
        serial_bus_pkg::bcd_display_t d;
        d.hundreds = serial_bus_pkg::bcd_digit_t'(v / 100);
        d.tens     = serial_bus_pkg::bcd_digit_t'((v / 10) % 10);
        d.ones     = serial_bus_pkg::bcd_digit_t'(v % 10);
        return d;
    endfunction

    task automatic check(input bit ok, input string msg);
        assert (ok)
        else
        begin
            $display("FAIL %0t: %s", $time, msg);
            test_errs++;
        end
    endtask

    task automatic check_display(input string what, input serial_bus_pkg::bcd_display_t got,
                                 input serial_bus_pkg::bcd_display_t exp);
        check(got == exp, $sformatf("%s shows %h, expected %h", what, got, exp));
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (test_errs != 0)
        begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests_run, name, test_errs);
        end
        else
            $display("test %0d %s: ok", tests_run, name);
        test_errs = 0;
    endtask

    // one host frame, returns at the negedge after the displays settle
    task automatic send_host(input serial_bus_pkg::node_id_t dest,
                             input serial_bus_pkg::bus_data_t value, output int latency);
        int start;
        @(posedge clk);
        host_frame <= '{target: dest, payload: value};
        host_start <= 1'b1;
        @(negedge clk);
        start = cyc;
        @(posedge clk);
        host_start <= 1'b0;
        @(negedge clk);
        while (!host_done && cyc - start < WAIT_LIMIT)
            @(negedge clk);
        latency = cyc - start;
        if (!host_done)
        begin
            $display("timeout: host_done never arrived at %0t", $time);
            test_errs++;
        end
        @(negedge clk);
    endtask

    task automatic wait_display_b(input serial_bus_pkg::bcd_display_t exp);
        int waited;
        waited = 0;
        while (display_b != exp && waited < WAIT_LIMIT)
        begin
            @(negedge clk);
            waited++;
        end
        check_display("display_b", display_b, exp);
    endtask

    task automatic wait_bus_busy();
        int waited;
        waited = 0;
        while (!bus_util && waited < WAIT_LIMIT)
        begin
            @(negedge clk);
            waited++;
        end
        if (!bus_util)
        begin
            $display("timeout: no forward frame started by %0t", $time);
            test_errs++;
        end
    endtask

    initial
    begin
        int                           lat;
        int                           dones;
        serial_bus_pkg::bus_data_t    val;
        serial_bus_pkg::bus_data_t    corner[4];
        serial_bus_pkg::bus_frame_t   exp_frame;
        void'($urandom(32'hf3c46b14));
        corner = '{8'd0, 8'd99, 8'd100, 8'd255};
        rstn       = 1'b0;
        host_start = 1'b0;
        host_frame = '0;
        repeat (5) @(posedge clk);
        rstn <= 1'b1;
        @(negedge clk);

        check_display("display_a", display_a, '0);
        check_display("display_b", display_b, '0);
        check(!host_busy && !bus_util, "host_busy or bus_util high after reset");
        end_test("reset");

        send_host(serial_bus_pkg::NODE_B_ID, 8'd42, lat);
        exp_frame = '{target: serial_bus_pkg::NODE_B_ID, payload: 8'd42};
        check_display("display_b", display_b, expected_digits(42));
        check_display("display_a", display_a, expected_digits(0));
        check(lat == FRAME_CYC, $sformatf("host latency %0d, expected %0d", lat, FRAME_CYC));
        check(rx_frames.size() == 1 && rx_frames[0] == exp_frame,
              "bus_serial did not carry exactly the host frame");
        end_test("host to node b");

        send_host(serial_bus_pkg::NODE_A_ID, 8'd137, lat);
        check_display("display_a", display_a, expected_digits(137));
        wait_display_b(expected_digits(137));  // after settle and forward
        end_test("forward a to b");

        for (int i = 0; i < NUM_RAND + 4; i++)
        begin
            if (i < NUM_RAND)
                val = serial_bus_pkg::bus_data_t'($urandom);
            else
                val = corner[i - NUM_RAND];  // corners last, ends on 255
            send_host(serial_bus_pkg::NODE_B_ID, val, lat);
            check_display("display_b", display_b, expected_digits(int'(val)));
        end
        end_test("bcd values");

        b_log.delete();
        send_host(serial_bus_pkg::NODE_A_ID, 8'd201, lat);
        wait_bus_busy();
        send_host(serial_bus_pkg::NODE_B_ID, 8'd58, lat);  // contends with node A
        @(negedge clk);  // let the display log catch up
        check(lat > FRAME_CYC, "host frame was not held back by the forward");
        check(b_log.size() >= 2, "display_b did not take both values");
        if (b_log.size() >= 2)
        begin
            check_display("forwarded display_b", b_log[b_log.size() - 2], expected_digits(201));
            check_display("display_b", b_log[b_log.size() - 1], expected_digits(58));
        end
        end_test("contention");

        dones = done_cnt;
        @(posedge clk);
        host_frame <= '{target: serial_bus_pkg::SPARE_ID, payload: 8'd77};
        host_start <= 1'b1;
        @(posedge clk);
        host_start <= 1'b0;
        repeat (3) @(posedge clk);
        host_frame <= '{target: serial_bus_pkg::NODE_B_ID, payload: 8'd11};
        host_start <= 1'b1;  // arrives while busy
        @(negedge clk);
        check(host_busy, "host not busy when the second start arrived");
        @(posedge clk);
        host_start <= 1'b0;
        repeat (WAIT_LIMIT) @(negedge clk);
        check(done_cnt == dones + 1, $sformatf("%0d host frames, expected 1", done_cnt - dones));
        check_display("display_a", display_a, expected_digits(201));
        check_display("display_b", display_b, expected_digits(58));
        end_test("spare id and busy start");

        $display("tests run %0d, failed %0d, assertion failures %0d",
                 tests_run, tests_failed, uut.u_sva.fail_cnt);
        if (tests_failed == 0 && uut.u_sva.fail_cnt == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/serial_bus_assertions.sv
// bound to serial_bus_top; checks assume a clean reset and frames of exactly FRAME_BITS bits
`default_nettype none

module serial_bus_assertions (
    input  wire logic                                   clk,
    input  wire logic                                   rstn,
    input  wire logic [serial_bus_pkg::NUM_MASTERS-1:0] grant,
    input  wire logic [serial_bus_pkg::NUM_MASTERS-1:0] tx_active,
    input  wire logic                                   bus_util,
    input  wire logic                                   host_start,
    input  wire logic                                   host_busy,
    input  wire logic                                   host_done,
    input  wire serial_bus_pkg::bcd_display_t           display_a,
    input  wire serial_bus_pkg::bcd_display_t           display_b
);

    int fail_cnt = 0;  // read by the testbench at the end
    int run_len;       // consecutive cycles of bus_util

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
            run_len <= 0;
        else if (bus_util)
            run_len <= run_len + 1;
        else
            run_len <= 0;
    end

    a_grant_onehot: assert property (@(posedge clk) disable iff (!rstn) $onehot0(grant))
    else
    begin
        $error("grant is not one-hot: %b", grant);
        fail_cnt++;
    end

    // only the owner of the line may shift
    a_shift_owned: assert property (@(posedge clk) disable iff (!rstn)
        (tx_active & ~grant) == '0)
    else
    begin
        $error("master shifting without grant: active %b grant %b", tx_active, grant);
        fail_cnt++;
    end

    a_run_max: assert property (@(posedge clk) disable iff (!rstn)
        bus_util |-> run_len < serial_bus_pkg::FRAME_BITS)
    else
    begin
        $error("bus_util high longer than one frame");
        fail_cnt++;
    end

    a_run_exact: assert property (@(posedge clk) disable iff (!rstn)
        (!bus_util && run_len != 0) |-> run_len == serial_bus_pkg::FRAME_BITS)
    else
    begin
        $error("frame ended after %0d bits", run_len);
        fail_cnt++;
    end

    // done right after the last bit, busy only from a start
    a_done_after_frame: assert property (@(posedge clk) disable iff (!rstn)
        host_done |-> $past(bus_util) && !host_busy)
    else
    begin
        $error("host_done without a frame just before it");
        fail_cnt++;
    end

    a_busy_from_start: assert property (@(posedge clk) disable iff (!rstn)
        $rose(host_busy) |-> $past(host_start))
    else
    begin
        $error("host_busy rose without host_start");
        fail_cnt++;
    end

    a_display_bcd: assert property (@(posedge clk) disable iff (!rstn)
        display_a.hundreds <= 4'd2 && display_a.tens <= 4'd9 && display_a.ones <= 4'd9 &&
        display_b.hundreds <= 4'd2 && display_b.tens <= 4'd9 && display_b.ones <= 4'd9)
    else
    begin
        $error("display digit out of range: a %h b %h", display_a, display_b);
        fail_cnt++;
    end

endmodule

bind serial_bus_top serial_bus_assertions u_sva (
    .clk        (clk),
    .rstn       (rstn),
    .grant      (grant),
    .tx_active  (tx_active),
    .bus_util   (bus_util),
    .host_start (host_start),
    .host_busy  (host_busy),
    .host_done  (host_done),
    .display_a  (display_a),
    .display_b  (display_b)
);

`default_nettype wire

//--- design/serial_bus_top.sv
// only node A forwards and always to node B, so a value crosses the bus at most twice
`default_nettype none

module serial_bus_top #(
    parameter int SETTLE_LEN = 4
) (
    input  logic                         clk,
    input  logic                         rstn,
    input  logic                         host_start,
    input  serial_bus_pkg::bus_frame_t   host_frame,
    output logic                         host_busy,
    output logic                         host_done,
    output serial_bus_pkg::bcd_display_t display_a,
    output serial_bus_pkg::bcd_display_t display_b,
    output logic                         bus_serial,
    output logic                         bus_util
);

    logic [serial_bus_pkg::NUM_MASTERS-1:0] req;
    logic [serial_bus_pkg::NUM_MASTERS-1:0] tx_bit;
    logic [serial_bus_pkg::NUM_MASTERS-1:0] tx_active;
    logic [serial_bus_pkg::NUM_MASTERS-1:0] grant;

    bus_master_port u_host (
        .clk       (clk),
        .rstn      (rstn),
        .execute   (host_start),
        .frame     (host_frame),
        .grant     (grant[serial_bus_pkg::HOST_IDX]),
        .req       (req[serial_bus_pkg::HOST_IDX]),
        .tx_bit    (tx_bit[serial_bus_pkg::HOST_IDX]),
        .tx_active (tx_active[serial_bus_pkg::HOST_IDX]),
        .busy      (host_busy),
        .done      (host_done)
    );

    bus_arbiter u_arb (
        .clk        (clk),
        .rstn       (rstn),
        .req        (req),
        .tx_bit     (tx_bit),
        .tx_active  (tx_active),
        .grant      (grant),
        .bus_serial (bus_serial),
        .bus_util   (bus_util)
    );

    // node A relays every received byte to node B
    display_node #(
        .SELF_ID    (serial_bus_pkg::NODE_A_ID),
        .SETTLE_LEN (SETTLE_LEN),
        .FWD_EN     (1'b1),
        .FWD_ID     (serial_bus_pkg::NODE_B_ID)
    ) u_node_a (
        .clk        (clk),
        .rstn       (rstn),
        .bus_serial (bus_serial),
        .bus_util   (bus_util),
        .grant      (grant[serial_bus_pkg::NODE_A_IDX]),
        .req        (req[serial_bus_pkg::NODE_A_IDX]),
        .tx_bit     (tx_bit[serial_bus_pkg::NODE_A_IDX]),
        .tx_active  (tx_active[serial_bus_pkg::NODE_A_IDX]),
        .display    (display_a)
    );

    display_node #(
        .SELF_ID    (serial_bus_pkg::NODE_B_ID),
        .SETTLE_LEN (SETTLE_LEN),
        .FWD_EN     (1'b0),
        .FWD_ID     (serial_bus_pkg::NODE_A_ID)
    ) u_node_b (
        .clk        (clk),
        .rstn       (rstn),
        .bus_serial (bus_serial),
        .bus_util   (bus_util),
        .grant      (grant[serial_bus_pkg::NODE_B_IDX]),
        .req        (req[serial_bus_pkg::NODE_B_IDX]),
        .tx_bit     (tx_bit[serial_bus_pkg::NODE_B_IDX]),
        .tx_active  (tx_active[serial_bus_pkg::NODE_B_IDX]),
        .display    (display_b)
    );

endmodule

`default_nettype wire

//--- design/display_node.sv
// a byte written during a forward updates the display but is not forwarded again
`default_nettype none

module display_node #(
    parameter serial_bus_pkg::node_id_t SELF_ID    = serial_bus_pkg::NODE_A_ID,
    parameter int                       SETTLE_LEN = 4,
    parameter bit                       FWD_EN     = 1'b0,
    parameter serial_bus_pkg::node_id_t FWD_ID     = serial_bus_pkg::NODE_B_ID
) (
    input  logic                         clk,
    input  logic                         rstn,
    input  logic                         bus_serial,
    input  logic                         bus_util,
    input  logic                         grant,
    output logic                         req,
    output logic                         tx_bit,
    output logic                         tx_active,
    output serial_bus_pkg::bcd_display_t display
);

    typedef enum logic [1:0] {
        n_idle,
        n_settle,
        n_send,
        n_wait
    } node_state_t;

    node_state_t                state;
    logic [SETTLE_LEN-1:0]      settle_cnt;
    serial_bus_pkg::bus_data_t  disp_buf;  // shown value
    serial_bus_pkg::bus_data_t  slv_data;
    serial_bus_pkg::bus_frame_t fwd_frame;
    logic                       slv_write;
    logic                       mst_exec;
    logic                       mst_busy;
    logic                       mst_done;

    bus_slave_port #(.SELF_ID(SELF_ID)) u_slave (
        .clk        (clk),
        .rstn       (rstn),
        .bus_serial (bus_serial),
        .bus_util   (bus_util),
        .write      (slv_write),
        .data       (slv_data)
    );

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            state      <= n_idle;
            settle_cnt <= '0;
            disp_buf   <= '0;
        end
        else
        begin
            if (slv_write)
                disp_buf <= slv_data;
            case (state)
                n_idle:
                begin
                    settle_cnt <= '0;
                    if (slv_write && FWD_EN)
                        state <= n_settle;
                end

                n_settle:
                begin
                    settle_cnt <= settle_cnt + 1'b1;
                    if (settle_cnt == '1)
                        state <= n_send;
                end

                n_send:   if (!mst_busy) state <= n_wait;   // strobe goes out here
                n_wait:   if (mst_done) state <= n_idle;
                default:  state <= n_idle;
            endcase
        end
    end

    // held in send until the master is free
    assign mst_exec  = (state == n_send) && !mst_busy;
    assign fwd_frame = '{target: FWD_ID, payload: disp_buf};

    bus_master_port u_master (
        .clk       (clk),
        .rstn      (rstn),
        .execute   (mst_exec),
        .frame     (fwd_frame),
        .grant     (grant),
        .req       (req),
        .tx_bit    (tx_bit),
        .tx_active (tx_active),
        .busy      (mst_busy),
        .done      (mst_done)
    );

    bin_to_bcd u_bcd (
        .value  (disp_buf),
        .digits (display)
    );

endmodule

`default_nettype wire

//--- design/bus_slave_port.sv
// accepts only whole frames of FRAME_BITS bits and has no acknowledge back to the master
`default_nettype none

module bus_slave_port #(
    parameter serial_bus_pkg::node_id_t SELF_ID = serial_bus_pkg::NODE_A_ID
) (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic                      bus_serial,
    input  logic                      bus_util,
    output logic                      write,
    output serial_bus_pkg::bus_data_t data
);

    localparam int FB    = serial_bus_pkg::FRAME_BITS;
    localparam int CNT_W = $clog2(FB);

    logic [FB-1:0]              shreg;
    logic [CNT_W-1:0]           bit_cnt;
    logic                       last_bit;
    serial_bus_pkg::bus_frame_t rx_frame;

    // frame including the bit now on the line
    assign rx_frame = {shreg[FB-2:0], bus_serial};
    assign last_bit = bus_util && (bit_cnt == CNT_W'(FB - 1));

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            bit_cnt <= '0;
            write   <= 1'b0;
        end
        else
        begin
            write <= 1'b0;
            if (last_bit)
            begin
                bit_cnt <= '0;
                write   <= (rx_frame.target == SELF_ID);
            end
            else if (bus_util)
                bit_cnt <= bit_cnt + 1'b1;
            else
                bit_cnt <= '0;  // line idle, realign
        end
    end

    always_ff @(posedge clk)
    begin
        if (bus_util)
            shreg <= rx_frame;
        if (last_bit)
            data <= rx_frame.payload;
    end

endmodule

`default_nettype wire

//--- design/bus_master_port.sv
// one frame per execute and execute is ignored while busy; req comes straight from execute
`default_nettype none

module bus_master_port (
    input  logic                       clk,
    input  logic                       rstn,
    input  logic                       execute,
    input  serial_bus_pkg::bus_frame_t frame,
    input  logic                       grant,
    output logic                       req,
    output logic                       tx_bit,
    output logic                       tx_active,
    output logic                       busy,
    output logic                       done
);

    localparam int FB    = serial_bus_pkg::FRAME_BITS;
    localparam int CNT_W = $clog2(FB);

    typedef enum logic [1:0] {
        m_idle,
        m_request,
        m_shift
    } master_state_t;

    master_state_t    state;
    logic [FB-1:0]    shreg;    // msb is on the line
    logic [CNT_W-1:0] bit_cnt;

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            state   <= m_idle;
            bit_cnt <= '0;
            done    <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            case (state)
                m_idle:
                begin
                    bit_cnt <= '0;
                    if (execute)
                        state <= m_request;
                end

                m_request:
                begin
                    if (grant)
                        state <= m_shift;
                end

                m_shift:
                begin
                    bit_cnt <= bit_cnt + 1'b1;
                    if (bit_cnt == CNT_W'(FB - 1))
                    begin
                        state <= m_idle;
                        done  <= 1'b1;  // last bit just left
                    end
                end

                default: state <= m_idle;
            endcase
        end
    end

    // frame capture and shift out
    always_ff @(posedge clk)
    begin
        if (state == m_idle && execute)
            shreg <= frame;
        else if (state == m_shift)
            shreg <= {shreg[FB-2:0], 1'b0};
    end

    assign busy      = (state != m_idle);
    assign req       = busy | execute;  // up from the strobe itself
    assign tx_active = (state == m_shift);
    assign tx_bit    = shreg[FB-1];

endmodule

`default_nettype wire

//--- design/bus_arbiter.sv
// grant changes only while the line is idle and a released grant costs one idle cycle
`default_nettype none

module bus_arbiter (
    input  logic                                   clk,
    input  logic                                   rstn,
    input  logic [serial_bus_pkg::NUM_MASTERS-1:0] req,
    input  logic [serial_bus_pkg::NUM_MASTERS-1:0] tx_bit,
    input  logic [serial_bus_pkg::NUM_MASTERS-1:0] tx_active,
    output logic [serial_bus_pkg::NUM_MASTERS-1:0] grant,
    output logic                                   bus_serial,
    output logic                                   bus_util
);

    localparam int N     = serial_bus_pkg::NUM_MASTERS;
    localparam int IDX_W = $clog2(N);

    logic [IDX_W-1:0] last_srv;  // master served most recently
    logic [N-1:0]     pick;
    logic [IDX_W-1:0] pick_idx;

    // search starts one past the last master served
    always_comb
    begin : rr_pick
        int   idx;
        logic found;
        found    = 1'b0;
        pick     = '0;
        pick_idx = last_srv;
        for (int i = 1; i <= N; i++)
        begin
            idx = (int'(last_srv) + i) % N;
            if (!found && req[idx])
            begin
                found     = 1'b1;
                pick[idx] = 1'b1;
                pick_idx  = IDX_W'(idx);
            end
        end
    end

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            grant    <= '0;
            last_srv <= IDX_W'(N - 1);  // host goes first
        end
        else if (|grant)
        begin
            if (!(|(grant & req)))
                grant <= '0;  // owner done
        end
        else if (!(|tx_active) && (|pick))
        begin
            grant    <= pick;
            last_srv <= pick_idx;
        end
    end

    assign bus_serial = |(tx_bit & grant);
    assign bus_util   = |(tx_active & grant);

endmodule

`default_nettype wire

//--- design/bin_to_bcd.sv
// purely combinational and covers the full byte range 0 to 255
`default_nettype none

module bin_to_bcd (
    input  serial_bus_pkg::bus_data_t    value,
    output serial_bus_pkg::bcd_display_t digits
);

    localparam int VW = $bits(serial_bus_pkg::bus_data_t);
    localparam int DW = $bits(serial_bus_pkg::bcd_digit_t);
    localparam int SW = VW + 3 * DW;

    // shift-and-add-three over all input bits
    always_comb
    begin : dabble
        logic [SW-1:0] sr;
        sr = {{(3 * DW){1'b0}}, value};
        for (int i = 0; i < VW; i++)
        begin
            if (sr[VW +: DW] > 4'd4)
                sr[VW +: DW] = sr[VW +: DW] + 4'd3;  // ones
            if (sr[VW + DW +: DW] > 4'd4)
                sr[VW + DW +: DW] = sr[VW + DW +: DW] + 4'd3;
            if (sr[VW + 2 * DW +: DW] > 4'd4)
                sr[VW + 2 * DW +: DW] = sr[VW + 2 * DW +: DW] + 4'd3;
            sr = sr << 1;
        end
        digits.hundreds = sr[VW + 2 * DW +: DW];
        digits.tens     = sr[VW + DW +: DW];
        digits.ones     = sr[VW +: DW];
    end

endmodule

`default_nettype wire

//--- design/serial_bus_pkg.sv
// frames carry a 2-bit node id and then one byte msb first, and id 0 reaches no node
`default_nettype none

package serial_bus_pkg;

    typedef logic [1:0] node_id_t;   // bus target id
    typedef logic [7:0] bus_data_t;  // payload byte
    typedef logic [3:0] bcd_digit_t; // one decimal digit

    // id goes out first, so it sits in the upper bits
    typedef struct packed {
        node_id_t  target;
        bus_data_t payload;
    } bus_frame_t;

    typedef struct packed {
        bcd_digit_t hundreds;
        bcd_digit_t tens;
        bcd_digit_t ones;
    } bcd_display_t;

    localparam int FRAME_BITS  = $bits(bus_frame_t);
    localparam int NUM_MASTERS = 3;

    // master slots on the arbiter
    localparam int HOST_IDX   = 0;
    localparam int NODE_A_IDX = 1;
    localparam int NODE_B_IDX = 2;

    localparam node_id_t SPARE_ID  = 2'd0;
    localparam node_id_t NODE_A_ID = 2'd1;
    localparam node_id_t NODE_B_ID = 2'd2;

endpackage

`default_nettype wire
